// File: decode_unit.f
hdl/rv_isa_pkg.sv
hdl/decode_pkg.sv
hdl/ir_classifier.sv
hdl/imm_extractor.sv
hdl/id_stage.sv
hdl/trap_fsm.sv
hdl/decode_counter.sv
hdl/decode_unit.sv
sim/tb_decode_unit.sv

// File: Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_decode_unit
RTL_TOP    = decode_unit
FILELIST   = decode_unit.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL TESTS PASSED"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_decode_unit.sv
`timescale 1ns/1ps

module tb_decode_unit
    import rv_isa_pkg::*, decode_pkg::*;
();

    localparam int CNT_WIDTH = 16;
    // About 300 cycles of tests, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [15:0] LFSR_SEED = 16'd15431;

    // Opcode mix for the random stream, slots 10 and 11 become mret and ecall
    localparam logic [6:0] RAND_OPS [0:15] = '{
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_REG_IMM,
        OP_REG_REG, OP_SYSTEM, OP_SYSTEM, OP_SYSTEM, OP_REG_IMM, OP_REG_REG, 7'h00, 7'h7F
    };

    logic                 clk;
    logic                 rst_n;
    rv_instr_u            ir;
    logic                 ir_valid;
    id_bundle_t           bundle;
    logic                 out_valid;
    trap_cause_e          trap_cause;
    logic [CNT_WIDTH-1:0] decoded_count;
    logic [CNT_WIDTH-1:0] illegal_count;

    // Expected DUT state after the most recent edge
    id_bundle_t           exp_bundle;
    logic                 exp_valid;
    trap_cause_e          exp_cause;
    logic [CNT_WIDTH-1:0] exp_decoded;
    logic [CNT_WIDTH-1:0] exp_illegal;

    logic [15:0] lfsr_state;
    int          error_count = 0;
    int          check_count = 0;
    int          tests_run = 0;
    int          cycle_count = 0;

    decode_unit #(
        .CNT_WIDTH (CNT_WIDTH)
    ) DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .ir            (ir),
        .ir_valid      (ir_valid),
        .bundle        (bundle),
        .out_valid     (out_valid),
        .trap_cause    (trap_cause),
        .decoded_count (decoded_count),
        .illegal_count (illegal_count)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not reach its end", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] enc(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // Reference decode straight from the RV32I field layout
    function automatic id_bundle_t ref_decode(input logic [31:0] w, input logic cause_ecall);
        id_bundle_t b;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       writes_reg;
        logic       writes_csr;
        f3 = w[14:12];
        f7 = w[31:25];
        b = '0;
        b.rs1 = w[19:15];
        b.rs2 = w[24:20];
        b.rd = w[11:7];
        b.funct3 = f3;
        b.funct7 = f7;
        b.csr_addr = w[31:20];
        b.is_mret = (w == MRET_WORD);
        b.is_ecall = (w == ECALL_WORD);
        writes_reg = 1'b1;
        writes_csr = 1'b0;
        case (w[6:0])
            OP_LUI, OP_AUIPC: b.imm = {w[31:12], 12'h000};
            OP_JAL: b.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OP_JALR: begin
                b.imm = {{20{w[31]}}, w[31:20]};
                b.is_illegal_ir = (f3 != 3'd0);
            end
            OP_BRANCH: begin
                b.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                b.is_illegal_ir = (f3 == 3'd2) || (f3 == 3'd3);
                writes_reg = 1'b0;
            end
            OP_LOAD: begin
                b.imm = {{20{w[31]}}, w[31:20]};
                b.is_illegal_ir = (f3 == 3'd3) || (f3 == 3'd6) || (f3 == 3'd7);
            end
            OP_STORE: begin
                b.imm = {{20{w[31]}}, w[31:25], w[11:7]};
                b.is_illegal_ir = (f3 > 3'd2);
                writes_reg = 1'b0;
            end
            OP_REG_IMM: begin
                if (f3 == 3'd1) begin
                    b.imm = {27'd0, w[24:20]};
                    b.is_illegal_ir = (f7 != 7'h00);
                end else if (f3 == 3'd5) begin
                    b.imm = {27'd0, w[24:20]};
                    b.is_illegal_ir = (f7 != 7'h00) && (f7 != 7'h20);
                end else begin
                    b.imm = {{20{w[31]}}, w[31:20]};
                end
            end
            OP_REG_REG: begin
                if ((f3 == 3'd0) || (f3 == 3'd5)) begin
                    b.is_illegal_ir = (f7 != 7'h00) && (f7 != 7'h20);
                end else begin
                    b.is_illegal_ir = (f7 != 7'h00);
                end
            end
            OP_SYSTEM: begin
                b.imm = {27'd0, w[19:15]};
                if (f3 == 3'd0) begin
                    b.is_illegal_ir = !(b.is_mret || b.is_ecall);
                    writes_reg = 1'b0;
                end else begin
                    b.is_illegal_ir = (f3 == 3'd4);
                    writes_csr = !((f3 == 3'd2) && (w[19:15] == 5'd0));
                end
            end
            default: begin
                b.is_illegal_ir = 1'b1;
                writes_reg = 1'b0;
            end
        endcase
        b.wr_reg_n = !(writes_reg && !b.is_illegal_ir && (w[11:7] != 5'd0));
        b.wr_csr_n = !(writes_csr && !b.is_illegal_ir);
        if (b.is_mret) begin
            b.csr_addr = MEPC_ADDR;
            b.imm = cause_ecall ? 32'd4 : 32'd0;
        end
        return b;
    endfunction

    function automatic trap_cause_e next_cause(input trap_cause_e cause, input id_bundle_t b,
                                               input logic valid);
        if (!valid) return cause;
        if (cause == CAUSE_NONE) begin
            if (b.is_ecall) return CAUSE_ECALL;
            if (b.is_illegal_ir) return CAUSE_ILLEGAL;
            return cause;
        end
        return b.is_mret ? CAUSE_NONE : cause;
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic compare_outputs();
        check_count++;
        if (bundle !== exp_bundle) begin
            error_count++;
            $display("CHECK FAILED bundle: got 0x%020h expected 0x%020h", bundle, exp_bundle);
        end
        check_value("out_valid", 32'(out_valid), 32'(exp_valid));
        check_value("trap_cause", 32'(trap_cause), 32'(exp_cause));
        check_value("decoded_count", 32'(decoded_count), 32'(exp_decoded));
        check_value("illegal_count", 32'(illegal_count), 32'(exp_illegal));
    endtask

    // Checks the outputs of the last edge, drives one cycle and steps the model
    task automatic clock_in(input logic [31:0] word, input logic valid);
        id_bundle_t next_b;
        @(posedge clk);
        #1;
        compare_outputs();
        ir = word;
        ir_valid = valid;
        next_b = ref_decode(word, exp_cause == CAUSE_ECALL);
        if (exp_valid) begin
            exp_decoded++;
            if (exp_bundle.is_illegal_ir) exp_illegal++;
        end
        exp_cause = next_cause(exp_cause, exp_bundle, exp_valid);
        if (valid) exp_bundle = next_b;
        exp_valid = valid;
    endtask

    task automatic send_one(input logic [31:0] word);
        clock_in(word, 1'b1);
        clock_in(32'h0, 1'b0);
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("%s finished with no errors", name);
        end else begin
            $display("%s finished with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset();
        int start;
        start = error_count;
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("trap_cause", 32'(trap_cause), 32'(CAUSE_NONE));
        check_value("decoded_count", 32'(decoded_count), 32'd0);
        check_value("illegal_count", 32'(illegal_count), 32'd0);
        check_value("bundle.imm", bundle.imm, 32'd0);
        report_test("test_reset", start);
    endtask

    task automatic test_field_decode();
        int          start;
        logic [31:0] words [15];
        start = error_count;
        words = '{
            enc(7'h09, 5'h0A, 5'h0B, 3'd4, 5'd5, OP_LUI),
            enc(7'h7F, 5'h11, 5'h1E, 3'd7, 5'd6, OP_AUIPC),
            enc(7'h55, 5'h13, 5'h07, 3'd2, 5'd1, OP_JAL),
            enc(7'h7F, 5'h1C, 5'd2, 3'd0, 5'd1, OP_JALR),
            enc(7'h41, 5'd3, 5'd4, 3'd4, 5'h15, OP_BRANCH),
            enc(7'h00, 5'h10, 5'd8, 3'd2, 5'd9, OP_LOAD),
            enc(7'h7E, 5'd9, 5'd8, 3'd1, 5'h1D, OP_STORE),
            enc(7'h7F, 5'h1F, 5'd1, 3'd0, 5'd2, OP_REG_IMM),
            enc(7'h00, 5'd7, 5'd3, 3'd1, 5'd4, OP_REG_IMM),
            enc(7'h20, 5'd31, 5'd3, 3'd5, 5'd4, OP_REG_IMM),
            enc(7'h00, 5'd2, 5'd3, 3'd0, 5'd10, OP_REG_REG),
            enc(7'h20, 5'd2, 5'd3, 3'd0, 5'd11, OP_REG_REG),
            enc(7'h00, 5'd2, 5'd3, 3'd7, 5'd12, OP_REG_REG),
            enc(7'h18, 5'h05, 5'd6, 3'd1, 5'd7, OP_SYSTEM),
            enc(7'h18, 5'h00, 5'd17, 3'd6, 5'd7, OP_SYSTEM)
        };
        foreach (words[k]) begin
            send_one(words[k]);
            check_value("bundle.is_illegal_ir", 32'(bundle.is_illegal_ir), 32'd0);
        end
        // Last word is csrrsi with uimm 17 on CSR 300 hex
        check_value("bundle.imm", bundle.imm, 32'd17);
        check_value("bundle.csr_addr", 32'(bundle.csr_addr), 32'h300);
        report_test("test_field_decode", start);
    endtask

    task automatic test_illegal_and_writes();
        int          start;
        logic [31:0] bad [15];
        start = error_count;
        bad = '{
            enc(7'h00, 5'd1, 5'd2, 3'd1, 5'd3, OP_JALR),
            enc(7'h00, 5'd1, 5'd2, 3'd2, 5'd3, OP_BRANCH),
            enc(7'h00, 5'd1, 5'd2, 3'd3, 5'd3, OP_BRANCH),
            enc(7'h00, 5'd1, 5'd2, 3'd3, 5'd3, OP_LOAD),
            enc(7'h00, 5'd1, 5'd2, 3'd6, 5'd3, OP_LOAD),
            enc(7'h00, 5'd1, 5'd2, 3'd7, 5'd3, OP_LOAD),
            enc(7'h00, 5'd1, 5'd2, 3'd4, 5'd3, OP_STORE),
            enc(7'h01, 5'd1, 5'd2, 3'd1, 5'd3, OP_REG_IMM),
            enc(7'h10, 5'd1, 5'd2, 3'd5, 5'd3, OP_REG_IMM),
            enc(7'h01, 5'd1, 5'd2, 3'd0, 5'd3, OP_REG_REG),
            enc(7'h20, 5'd1, 5'd2, 3'd1, 5'd3, OP_REG_REG),
            enc(7'h00, 5'd1, 5'd0, 3'd0, 5'd0, OP_SYSTEM),
            enc(7'h18, 5'h05, 5'd6, 3'd4, 5'd7, OP_SYSTEM),
            enc(7'h00, 5'd1, 5'd2, 3'd0, 5'd3, 7'h0B),
            32'hFFFF_FFFF
        };
        foreach (bad[k]) begin
            send_one(bad[k]);
            check_value("bundle.is_illegal_ir", 32'(bundle.is_illegal_ir), 32'd1);
            check_value("bundle.wr_reg_n", 32'(bundle.wr_reg_n), 32'd1);
            check_value("bundle.wr_csr_n", 32'(bundle.wr_csr_n), 32'd1);
        end
        // Leave the illegal trap before the write checks
        send_one(MRET_WORD);
        clock_in(32'h0, 1'b0);
        send_one(enc(7'h00, 5'd5, 5'd1, 3'd0, 5'd0, OP_REG_IMM));
        check_value("bundle.wr_reg_n", 32'(bundle.wr_reg_n), 32'd1);
        send_one(enc(7'h18, 5'h00, 5'd0, 3'd2, 5'd7, OP_SYSTEM));
        check_value("bundle.wr_csr_n", 32'(bundle.wr_csr_n), 32'd1);
        check_value("bundle.wr_reg_n", 32'(bundle.wr_reg_n), 32'd0);
        send_one(enc(7'h18, 5'h00, 5'd3, 3'd2, 5'd7, OP_SYSTEM));
        check_value("bundle.wr_csr_n", 32'(bundle.wr_csr_n), 32'd0);
        report_test("test_illegal_and_writes", start);
    endtask

    task automatic test_trap_sequence();
        int start;
        start = error_count;
        send_one(ECALL_WORD);
        clock_in(32'h0, 1'b0);
        check_value("trap_cause", 32'(trap_cause), 32'(CAUSE_ECALL));
        send_one(MRET_WORD);
        check_value("bundle.imm", bundle.imm, 32'd4);
        check_value("bundle.csr_addr", 32'(bundle.csr_addr), 32'h341);
        clock_in(32'h0, 1'b0);
        check_value("trap_cause", 32'(trap_cause), 32'(CAUSE_NONE));
        send_one(32'hFFFF_FFFF);
        clock_in(32'h0, 1'b0);
        check_value("trap_cause", 32'(trap_cause), 32'(CAUSE_ILLEGAL));
        send_one(MRET_WORD);
        check_value("bundle.imm", bundle.imm, 32'd0);
        clock_in(32'h0, 1'b0);
        check_value("trap_cause", 32'(trap_cause), 32'(CAUSE_NONE));
        // mret without a pending trap
        send_one(MRET_WORD);
        check_value("bundle.imm", bundle.imm, 32'd0);
        report_test("test_trap_sequence", start);
    endtask

    task automatic test_random_stream();
        int                   start;
        int                   bad_tally;
        logic [CNT_WIDTH-1:0] dec_start;
        logic [CNT_WIDTH-1:0] ill_start;
        logic [31:0]          r;
        logic [31:0]          w;
        id_bundle_t           b;
        start = error_count;
        bad_tally = 0;
        dec_start = exp_decoded;
        ill_start = exp_illegal;
        for (int n = 0; n < 200; n++) begin
            r = take_bits(4);
            w = take_bits(25) << 7;
            w[6:0] = RAND_OPS[r[3:0]];
            // Half the words get a funct7 that is usually legal
            if (take_bits(1) == 32'd1) begin
                w[31:25] = (take_bits(1) == 32'd1) ? 7'h20 : 7'h00;
            end
            if (r[3:0] == 4'd10) w = MRET_WORD;
            if (r[3:0] == 4'd11) w = ECALL_WORD;
            b = ref_decode(w, 1'b0);
            if (b.is_illegal_ir) bad_tally++;
            clock_in(w, 1'b1);
        end
        repeat (3) clock_in(32'h0, 1'b0);
        check_value("decoded_count", 32'(decoded_count), 32'(dec_start) + 32'd200);
        check_value("illegal_count", 32'(illegal_count), 32'(ill_start) + 32'(bad_tally));
        report_test("test_random_stream", start);
    endtask

    initial begin
        rst_n = 1'b0;
        ir = '0;
        ir_valid = 1'b0;
        lfsr_state = LFSR_SEED;
        exp_bundle = '0;
        exp_valid = 1'b0;
        exp_cause = CAUSE_NONE;
        exp_decoded = '0;
        exp_illegal = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_field_decode();
        test_illegal_and_writes();
        test_trap_sequence();
        test_random_stream();
        $display("Tests run %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/1ps

module decode_unit
    import rv_isa_pkg::*;
    import decode_pkg::*;
#(
    parameter int CNT_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_instr_u            ir,
    input  logic                 ir_valid,
    output id_bundle_t           bundle,
    output logic                 out_valid,
    output trap_cause_e          trap_cause,
    output logic [CNT_WIDTH-1:0] decoded_count,
    output logic [CNT_WIDTH-1:0] illegal_count
);

    ir_type_e ir_type;
    logic     is_e_cause_eq_ecall;

    ir_classifier u_ir_classifier (
        .ir      (ir),
        .ir_type (ir_type)
    );

    id_stage u_id_stage (
        .clk                 (clk),
        .rst_n               (rst_n),
        .ir                  (ir),
        .ir_type             (ir_type),
        .ir_valid            (ir_valid),
        .is_e_cause_eq_ecall (is_e_cause_eq_ecall),
        .bundle              (bundle),
        .out_valid           (out_valid)
    );

    // Trap cause feeds back into the mret return offset
    trap_fsm u_trap_fsm (
        .clk                 (clk),
        .rst_n               (rst_n),
        .bundle              (bundle),
        .out_valid           (out_valid),
        .trap_cause          (trap_cause),
        .is_e_cause_eq_ecall (is_e_cause_eq_ecall)
    );

    decode_counter #(
        .CNT_WIDTH (CNT_WIDTH)
    ) u_decode_counter (
        .clk           (clk),
        .rst_n         (rst_n),
        .out_valid     (out_valid),
        .is_illegal_ir (bundle.is_illegal_ir),
        .decoded_count (decoded_count),
        .illegal_count (illegal_count)
    );

endmodule

// File: hdl/decode_counter.sv
`timescale 1ns/1ps

module decode_counter #(
    parameter int CNT_WIDTH = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 out_valid,
    input  logic                 is_illegal_ir,
    output logic [CNT_WIDTH-1:0] decoded_count,
    output logic [CNT_WIDTH-1:0] illegal_count
);

    // Both counters wrap at full scale
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decoded_count <= '0;
            illegal_count <= '0;
        end else if (out_valid) begin
            decoded_count <= decoded_count + 1'b1;
            if (is_illegal_ir) begin
                illegal_count <= illegal_count + 1'b1;
            end
        end
    end

    a_illegal_with_decoded: assert property (@(posedge clk) disable iff (!rst_n)
        (illegal_count != $past(illegal_count)) |->
            (decoded_count != $past(decoded_count)));

endmodule

// File: hdl/trap_fsm.sv
`timescale 1ns/1ps

module trap_fsm
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  id_bundle_t  bundle,
    input  logic        out_valid,
    output trap_cause_e trap_cause,
    output logic        is_e_cause_eq_ecall
);

    typedef enum logic [1:0] {
        RUN          = 2'b00,
        TRAP_ECALL   = 2'b01,
        TRAP_ILLEGAL = 2'b10
    } state_e;

    state_e state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RUN;
        end else if (out_valid) begin
            case (state)
                RUN: begin
                    if (bundle.is_ecall) begin
                        state <= TRAP_ECALL;
                    end else if (bundle.is_illegal_ir) begin
                        state <= TRAP_ILLEGAL;
                    end
                end
                // Stay in the trap until the handler returns
                TRAP_ECALL, TRAP_ILLEGAL: begin
                    if (bundle.is_mret) begin
                        state <= RUN;
                    end
                end
                default: state <= RUN;
            endcase
        end
    end

    always_comb begin
        case (state)
            TRAP_ECALL:   trap_cause = CAUSE_ECALL;
            TRAP_ILLEGAL: trap_cause = CAUSE_ILLEGAL;
            default:      trap_cause = CAUSE_NONE;
        endcase
    end

    assign is_e_cause_eq_ecall = (state == TRAP_ECALL);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {RUN, TRAP_ECALL, TRAP_ILLEGAL});

endmodule

// File: hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage
    import rv_isa_pkg::*;
    import decode_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  rv_instr_u  ir,
    input  ir_type_e   ir_type,
    input  logic       ir_valid,
    input  logic       is_e_cause_eq_ecall,
    output id_bundle_t bundle,
    output logic       out_valid
);

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

    imm_type_e   imm_type;
    logic [31:0] raw_imm;
    logic        is_mret;
    logic        is_ecall;
    logic        is_illegal;
    logic        wr_reg_n;
    logic        wr_csr_n;
    logic        funct7_zero;
    logic        funct7_alt_ok;
    id_bundle_t  next_bundle;

    assign is_mret  = (ir == MRET_WORD);
    assign is_ecall = (ir == ECALL_WORD);

    assign funct7_zero   = (ir.r.funct7 == 7'd0);
    assign funct7_alt_ok = funct7_zero || (ir.r.funct7 == FUNCT7_ALT);

    always_comb begin
        case (ir_type)
            IR_LUI, IR_AUIPC:   imm_type = IMM_U;
            IR_JAL:             imm_type = IMM_J;
            IR_JALR, IR_LOAD:   imm_type = IMM_I;
            IR_BRANCH:          imm_type = IMM_B;
            IR_STORE:           imm_type = IMM_S;
            IR_REG_IMM: begin
                // SLLI, SRLI and SRAI carry a shift amount
                if ((ir.r.funct3 == FUNCT3_SLL) || (ir.r.funct3 == FUNCT3_SR)) begin
                    imm_type = IMM_SHAMT;
                end else begin
                    imm_type = IMM_I;
                end
            end
            IR_CSR, IR_SYS_CALL: imm_type = IMM_CSR;
            default:             imm_type = IMM_NONE;
        endcase
    end

    imm_extractor u_imm_extractor (
        .ir       (ir),
        .imm_type (imm_type),
        .imm      (raw_imm)
    );

    always_comb begin
        case (ir_type)
            IR_LUI, IR_AUIPC, IR_JAL: is_illegal = 1'b0;
            IR_JALR:   is_illegal = (ir.r.funct3 != FUNCT3_JALR);
            IR_BRANCH: is_illegal = (ir.r.funct3 == 3'b010) || (ir.r.funct3 == 3'b011);
            IR_LOAD: begin
                is_illegal = (ir.r.funct3 == 3'b011) || (ir.r.funct3 == 3'b110) ||
                             (ir.r.funct3 == 3'b111);
            end
            IR_STORE: begin
                is_illegal = (ir.r.funct3 != FUNCT3_SB) && (ir.r.funct3 != FUNCT3_SH) &&
                             (ir.r.funct3 != FUNCT3_SW);
            end
            IR_REG_IMM: begin
                if (ir.r.funct3 == FUNCT3_SLL) begin
                    is_illegal = !funct7_zero;
                end else if (ir.r.funct3 == FUNCT3_SR) begin
                    is_illegal = !funct7_alt_ok;
                end else begin
                    is_illegal = 1'b0;
                end
            end
            IR_REG_REG: begin
                // SUB and SRA use the alternate funct7
                if ((ir.r.funct3 == FUNCT3_ADD) || (ir.r.funct3 == FUNCT3_SR)) begin
                    is_illegal = !funct7_alt_ok;
                end else begin
                    is_illegal = !funct7_zero;
                end
            end
            // Only mret and ecall are supported here
            IR_SYS_CALL: is_illegal = !(is_mret || is_ecall);
            IR_CSR:      is_illegal = (ir.r.funct3 == 3'b100);
            default:     is_illegal = 1'b1;
        endcase
    end

    always_comb begin
        if (is_illegal || (ir.r.rd == 5'd0)) begin
            wr_reg_n = 1'b1;
        end else begin
            case (ir_type)
                IR_LUI, IR_AUIPC, IR_REG_IMM, IR_REG_REG,
                IR_LOAD, IR_JAL, IR_JALR, IR_CSR: wr_reg_n = 1'b0;
                default:                          wr_reg_n = 1'b1;
            endcase
        end
    end

    // CSRRS with rs1 x0 is a plain CSR read
    assign wr_csr_n = is_illegal || (ir_type != IR_CSR) ||
                      ((ir.r.funct3 == FUNCT3_CSRRS) && (ir.r.rs1 == 5'd0));

    always_comb begin
        next_bundle.rs1           = ir.r.rs1;
        next_bundle.rs2           = ir.r.rs2;
        next_bundle.rd            = ir.r.rd;
        next_bundle.funct3        = ir.r.funct3;
        next_bundle.funct7        = ir.r.funct7;
        next_bundle.csr_addr      = is_mret ? MEPC_ADDR : ir.i.imm12;
        // Return past the ecall, but retry the faulting instruction
        next_bundle.imm           = (is_mret && is_e_cause_eq_ecall) ? 32'd4 : raw_imm;
        next_bundle.wr_reg_n      = wr_reg_n;
        next_bundle.wr_csr_n      = wr_csr_n;
        next_bundle.is_mret       = is_mret;
        next_bundle.is_ecall      = is_ecall;
        next_bundle.is_illegal_ir = is_illegal;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bundle    <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= ir_valid;
            if (ir_valid) begin
                bundle <= next_bundle;
            end
        end
    end

    a_mret_ecall_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> !(bundle.is_mret && bundle.is_ecall));

    a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && bundle.is_illegal_ir) |-> (bundle.wr_reg_n && bundle.wr_csr_n));

endmodule

// File: hdl/imm_extractor.sv
`timescale 1ns/1ps

module imm_extractor
    import rv_isa_pkg::*;
(
    input  rv_instr_u   ir,
    input  imm_type_e   imm_type,
    output logic [31:0] imm
);

    logic sign;

    assign sign = ir.i.imm12[11];

    always_comb begin
        case (imm_type)
            IMM_I: imm = {{20{sign}}, ir.i.imm12};
            // Store offset is split across funct7 and rd
            IMM_S: imm = {{20{sign}}, ir.r.funct7, ir.r.rd};
            IMM_B: begin
                imm = {{19{sign}}, sign, ir.r.rd[0], ir.r.funct7[5:0], ir.r.rd[4:1], 1'b0};
            end
            IMM_U: imm = {ir.i.imm12, ir.i.rs1, ir.i.funct3, 12'h000};
            IMM_J: begin
                imm = {{11{sign}}, sign, ir.i.rs1, ir.i.funct3, ir.i.imm12[0],
                       ir.i.imm12[10:1], 1'b0};
            end
            // Shift amount sits in the rs2 slot
            IMM_SHAMT: imm = {27'd0, ir.r.rs2};
            // uimm of the CSR immediate forms
            IMM_CSR: imm = {27'd0, ir.i.rs1};
            default: imm = 32'd0;
        endcase
    end

endmodule

// File: hdl/ir_classifier.sv
`timescale 1ns/1ps

module ir_classifier
    import rv_isa_pkg::*;
(
    input  rv_instr_u ir,
    output ir_type_e  ir_type
);

    always_comb begin
        case (ir.r.opcode)
            OP_LUI:     ir_type = IR_LUI;
            OP_AUIPC:   ir_type = IR_AUIPC;
            OP_JAL:     ir_type = IR_JAL;
            OP_JALR:    ir_type = IR_JALR;
            OP_BRANCH:  ir_type = IR_BRANCH;
            OP_LOAD:    ir_type = IR_LOAD;
            OP_STORE:   ir_type = IR_STORE;
            OP_REG_IMM: ir_type = IR_REG_IMM;
            OP_REG_REG: ir_type = IR_REG_REG;
            OP_SYSTEM: begin
                // ecall, ebreak and mret share funct3 000 with each other
                if (ir.r.funct3 == FUNCT3_SYS_CALL) begin
                    ir_type = IR_SYS_CALL;
                end else begin
                    ir_type = IR_CSR;
                end
            end
            default:    ir_type = IR_UNKNOWN;
        endcase
    end

endmodule

// File: hdl/decode_pkg.sv
package decode_pkg;

    // Decoded instruction handed to the execute side
    typedef struct packed {
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] csr_addr;
        logic [31:0] imm;
        // Write enables, 0 means write
        logic        wr_reg_n;
        logic        wr_csr_n;
        logic        is_mret;
        logic        is_ecall;
        logic        is_illegal_ir;
    } id_bundle_t;

    // Reason for the current trap
    typedef enum logic [1:0] {
        CAUSE_NONE,
        CAUSE_ECALL,
        CAUSE_ILLEGAL
    } trap_cause_e;

    // mepc, source of the mret return address
    localparam logic [11:0] MEPC_ADDR = 12'h341;

endpackage

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Instruction classes as seen by the decoder
    typedef enum logic [3:0] {
        IR_LUI,
        IR_AUIPC,
        IR_JAL,
        IR_JALR,
        IR_BRANCH,
        IR_LOAD,
        IR_STORE,
        IR_REG_IMM,
        IR_REG_REG,
        IR_SYS_CALL,
        IR_CSR,
        IR_UNKNOWN
    } ir_type_e;

    // Immediate formats
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT,
        IMM_CSR,
        IMM_NONE
    } imm_type_e;

    localparam logic [2:0] FUNCT3_JALR     = 3'b000;
    localparam logic [2:0] FUNCT3_SB       = 3'b000;
    localparam logic [2:0] FUNCT3_SH       = 3'b001;
    localparam logic [2:0] FUNCT3_SW       = 3'b010;
    localparam logic [2:0] FUNCT3_ADD      = 3'b000;
    localparam logic [2:0] FUNCT3_SLL      = 3'b001;
    localparam logic [2:0] FUNCT3_SR       = 3'b101;
    localparam logic [2:0] FUNCT3_CSRRS    = 3'b010;
    localparam logic [2:0] FUNCT3_SYS_CALL = 3'b000;

    localparam logic [6:0] OP_LUI     = 7'b0110111;
    localparam logic [6:0] OP_AUIPC   = 7'b0010111;
    localparam logic [6:0] OP_JAL     = 7'b1101111;
    localparam logic [6:0] OP_JALR    = 7'b1100111;
    localparam logic [6:0] OP_BRANCH  = 7'b1100011;
    localparam logic [6:0] OP_LOAD    = 7'b0000011;
    localparam logic [6:0] OP_STORE   = 7'b0100011;
    localparam logic [6:0] OP_REG_IMM = 7'b0010011;
    localparam logic [6:0] OP_REG_REG = 7'b0110011;
    localparam logic [6:0] OP_SYSTEM  = 7'b1110011;

    // R-type layout, also covers the S and B field positions
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_reg_view_t;

    // I-type layout, upper twelve bits as one field
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_imm_view_t;

    typedef union packed {
        rv_reg_view_t r;
        rv_imm_view_t i;
    } rv_instr_u;

    localparam logic [31:0] MRET_WORD  = {7'b0011000, 5'b00010, 5'b00000, 3'b000, 5'b00000,
                                          OP_SYSTEM};
    localparam logic [31:0] ECALL_WORD = {12'h000, 5'b00000, 3'b000, 5'b00000, OP_SYSTEM};

endpackage
